//--- hw/riscv_params.svh
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// opcode field, instruction bits 6 to 2
`define OPC_LUI_5        5'b01101
`define OPC_AUIPC_5      5'b00101
`define OPC_JAL_5        5'b11011
`define OPC_JALR_5       5'b11001
`define OPC_BRANCH_5     5'b11000
`define OPC_STORE_5      5'b01000
`define OPC_LOAD_5       5'b00000
`define OPC_ARI_RTYPE_5  5'b01100
`define OPC_ARI_ITYPE_5  5'b00100
`define OPC_CSR_5        5'b11100

// branch funct3
`define FNC_BEQ          3'b000
`define FNC_BNE          3'b001
`define FNC_BLT          3'b100
`define FNC_BGE          3'b101
`define FNC_BLTU         3'b110
`define FNC_BGEU         3'b111

// memory-mapped performance counters
`define IO_CYC_ADDR      32'h80000010
`define IO_INSTR_ADDR    32'h80000014
`define IO_CNT_CLR_ADDR  32'h80000018
`define IO_BR_ADDR       32'h8000001c
`define IO_BR_OK_ADDR    32'h80000020

// addi x0, x0, 0
`define INSTR_NOP        32'h00000013

`endif

//--- hw/ctrl_pkg.sv
package ctrl_pkg;

    // stage-3 control outputs
    typedef struct packed {
        logic [2:0] mem_sel;
        logic [1:0] wb_sel;
        logic       reg_we;
    } s3_ctrl_t;

    // stage-2 verdict on a conditional branch
    typedef struct packed {
        logic is_branch;
        logic taken;
    } br_resolve_t;

    typedef struct packed {
        logic [31:0] cyc;
        logic [31:0] instr;
        logic [31:0] br;
        logic [31:0] br_ok;
    } perf_counts_t;

    // uart status and receive byte
    typedef struct packed {
        logic       rx_valid;
        logic       tx_ready;
        logic [7:0] rx_data;
    } uart_in_t;

endpackage

//--- hw/branch_comp.sv
`timescale 1ns/1ps

module branch_comp (
    input  logic [31:0] instruction_s2,
    input  logic [31:0] rs1,
    input  logic [31:0] rs2,
    output logic        breq,
    output logic        brlt
);
    logic is_unsigned;

    // funct3 bit 1 set for bltu and bgeu
    assign is_unsigned = instruction_s2[13];

    assign breq = (rs1 == rs2);

    always_comb begin
        if (is_unsigned) begin
            brlt = (rs1 < rs2);
        end else begin
            brlt = ($signed(rs1) < $signed(rs2));
        end
    end

endmodule

//--- hw/s3_control.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module s3_control (
    input  logic                   rst,
    input  logic [31:0]            instruction_s3,
    input  logic [31:0]            instruction_s2,
    input  logic [31:0]            addr,
    input  logic                   breq,
    input  logic                   brlt,
    input  logic                   is_jal,
    input  ctrl_pkg::uart_in_t     uart,
    input  ctrl_pkg::perf_counts_t counts,
    output logic [1:0]             pc_sel,
    output ctrl_pkg::s3_ctrl_t     ctrl,
    output ctrl_pkg::br_resolve_t  br_res,
    output logic [31:0]            io_value
);
    logic [4:0]  opcode_s3;
    logic [4:0]  opcode_s2;
    logic [2:0]  funct3_s2;
    logic        cond_met;
    logic        is_branch;
    logic        taken;
    logic [2:0]  mem_sel;
    logic [1:0]  wb_sel;
    logic        reg_we;
    logic [31:0] counter_value;
    logic [31:0] uart_value;

    assign opcode_s3 = instruction_s3[6:2];
    assign opcode_s2 = instruction_s2[6:2];
    assign funct3_s2 = instruction_s2[14:12];

    // branch condition from comparator levels
    always_comb begin
        case (funct3_s2)
            `FNC_BEQ:  cond_met = breq;
            `FNC_BNE:  cond_met = ~breq;
            `FNC_BLT:  cond_met = brlt;
            `FNC_BGE:  cond_met = ~brlt;
            `FNC_BLTU: cond_met = brlt;
            `FNC_BGEU: cond_met = ~brlt;
            default:   cond_met = 1'b0;
        endcase
    end

    assign is_branch = (opcode_s2 == `OPC_BRANCH_5);
    assign taken     = is_branch & cond_met;

    assign br_res.is_branch = is_branch;
    assign br_res.taken     = taken;

    // pc source, reset first, then jal, then jalr or taken branch
    always_comb begin
        if (rst) begin
            pc_sel = 2'd3;
        end else if (is_jal) begin
            pc_sel = 2'd2;
        end else if (opcode_s2 == `OPC_JALR_5) begin
            pc_sel = 2'd1;
        end else if (taken) begin
            pc_sel = 2'd1;
        end else begin
            pc_sel = 2'd0;
        end
    end

    // writeback source and register write from stage-3 opcode
    always_comb begin
        case (opcode_s3)
            `OPC_LUI_5, `OPC_AUIPC_5, `OPC_ARI_RTYPE_5, `OPC_ARI_ITYPE_5: begin
                wb_sel = 2'd1;
                reg_we = 1'b1;
            end
            `OPC_JAL_5, `OPC_JALR_5: begin
                wb_sel = 2'd2;
                reg_we = 1'b1;
            end
            `OPC_LOAD_5: begin
                wb_sel = 2'd0;
                reg_we = 1'b1;
            end
            `OPC_BRANCH_5, `OPC_STORE_5: begin
                wb_sel = 2'd0;
                reg_we = 1'b0;
            end
            // csr lands here too
            default: begin
                wb_sel = 2'd1;
                reg_we = 1'b0;
            end
        endcase
    end

    // region decode: 00 dmem, 01 bios, 10 io
    always_comb begin
        case (addr[31:30])
            2'b00:   mem_sel = 3'd1;
            2'b01:   mem_sel = 3'd0;
            2'b10:   mem_sel = 3'd2;
            default: mem_sel = 3'd1;
        endcase
    end

    assign ctrl.mem_sel = mem_sel;
    assign ctrl.wb_sel  = wb_sel;
    assign ctrl.reg_we  = reg_we;

    // counter reads need an exact address match
    always_comb begin
        case (addr)
            `IO_CYC_ADDR:   counter_value = counts.cyc;
            `IO_INSTR_ADDR: counter_value = counts.instr;
            `IO_BR_ADDR:    counter_value = counts.br;
            `IO_BR_OK_ADDR: counter_value = counts.br_ok;
            default:        counter_value = 32'd0;
        endcase
    end

    assign uart_value = addr[2] ? {24'd0, uart.rx_data}
                                : {30'd0, uart.rx_valid, uart.tx_ready};

    assign io_value = addr[4] ? counter_value : uart_value;

endmodule

//--- hw/perf_counters.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module perf_counters (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            instruction_s3,
    input  ctrl_pkg::br_resolve_t  br_res,
    input  logic                   br_pred_taken,
    input  logic                   io_we,
    input  logic [31:0]            addr,
    output ctrl_pkg::perf_counts_t counts
);
    logic clear_store;
    logic retired;
    logic pred_ok;

    // software clears all four with a store to the clear address
    assign clear_store = io_we & (addr == `IO_CNT_CLR_ADDR);

    // bubbles in stage 3 do not count as retired
    assign retired = (instruction_s3 != `INSTR_NOP);

    assign pred_ok = br_res.is_branch & (br_res.taken == br_pred_taken);

    always_ff @(posedge clk) begin
        if (rst || clear_store) begin
            counts <= '0;
        end else begin
            counts.cyc <= counts.cyc + 32'd1;
            if (retired) begin
                counts.instr <= counts.instr + 32'd1;
            end
            if (br_res.is_branch) begin
                counts.br <= counts.br + 32'd1;
            end
            if (pred_ok) begin
                counts.br_ok <= counts.br_ok + 32'd1;
            end
        end
    end

endmodule

//--- hw/cpu_ctrl_top.sv
`timescale 1ns/1ps

module cpu_ctrl_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           instruction_s2,
    input  logic [31:0]           instruction_s3,
    input  logic [31:0]           rs1,
    input  logic [31:0]           rs2,
    input  logic [31:0]           addr,
    input  logic                  io_we,
    input  logic                  is_jal,
    input  logic                  br_pred_taken,
    input  ctrl_pkg::uart_in_t    uart,
    output logic [1:0]            pc_sel,
    output ctrl_pkg::s3_ctrl_t    ctrl,
    output logic [31:0]           io_value
);
    logic                   breq;
    logic                   brlt;
    ctrl_pkg::br_resolve_t  br_res;
    ctrl_pkg::perf_counts_t counts;

    branch_comp u_branch_comp (
        .instruction_s2 (instruction_s2),
        .rs1            (rs1),
        .rs2            (rs2),
        .breq           (breq),
        .brlt           (brlt)
    );

    s3_control u_s3_control (
        .rst            (rst),
        .instruction_s3 (instruction_s3),
        .instruction_s2 (instruction_s2),
        .addr           (addr),
        .breq           (breq),
        .brlt           (brlt),
        .is_jal         (is_jal),
        .uart           (uart),
        .counts         (counts),
        .pc_sel         (pc_sel),
        .ctrl           (ctrl),
        .br_res         (br_res),
        .io_value       (io_value)
    );

    // counters see the branch verdict from stage 2
    perf_counters u_perf_counters (
        .clk            (clk),
        .rst            (rst),
        .instruction_s3 (instruction_s3),
        .br_res         (br_res),
        .br_pred_taken  (br_pred_taken),
        .io_we          (io_we),
        .addr           (addr),
        .counts         (counts)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

//--- sim/cpu_ctrl_tb.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module cpu_ctrl_tb;
    localparam int clk_period = 8;
    // reset, branches, writeback, regions, uart, counters
    localparam int test_cycles = 10 + 40 + 15 + 20 + 20 + 80;
    localparam logic [2:0] branch_f3 [6] = '{`FNC_BEQ, `FNC_BNE, `FNC_BLT, `FNC_BGE,
                                             `FNC_BLTU, `FNC_BGEU};
    // last entry is fence which lies outside the table
    localparam logic [4:0] opcodes [11] = '{`OPC_LUI_5, `OPC_AUIPC_5, `OPC_JAL_5,
        `OPC_JALR_5, `OPC_BRANCH_5, `OPC_STORE_5, `OPC_LOAD_5, `OPC_ARI_RTYPE_5,
        `OPC_ARI_ITYPE_5, `OPC_CSR_5, 5'b00011};
    localparam logic [31:0] counter_addrs [4] = '{`IO_CYC_ADDR, `IO_INSTR_ADDR,
                                                  `IO_BR_ADDR, `IO_BR_OK_ADDR};

    logic                   clk;
    logic                   rst;
    logic [31:0]            instruction_s2;
    logic [31:0]            instruction_s3;
    logic [31:0]            rs1;
    logic [31:0]            rs2;
    logic [31:0]            addr;
    logic                   io_we;
    logic                   is_jal;
    logic                   br_pred_taken;
    ctrl_pkg::uart_in_t     uart;
    logic [1:0]             pc_sel;
    ctrl_pkg::s3_ctrl_t     ctrl;
    logic [31:0]            io_value;
    ctrl_pkg::perf_counts_t model;
    logic [31:0]            rng;
    int                     err_count = 0;
    int                     errs_at_start = 0;
    int                     pass_tests = 0;
    int                     fail_tests = 0;

    tb_clock #(.period(clk_period)) u_clock (.clk(clk));

    cpu_ctrl_top UUT (
        .clk(clk), .rst(rst), .instruction_s2(instruction_s2),
        .instruction_s3(instruction_s3), .rs1(rs1), .rs2(rs2), .addr(addr),
        .io_we(io_we), .is_jal(is_jal), .br_pred_taken(br_pred_taken), .uart(uart),
        .pc_sel(pc_sel), .ctrl(ctrl), .io_value(io_value)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // imm 0, rs1 x1, rd x2
    function automatic logic [31:0] make_instr(input logic [4:0] opc, input logic [2:0] f3);
        return {12'd0, 5'd1, f3, 5'd2, opc, 2'b11};
    endfunction

    function automatic logic branch_taken(input logic [31:0] ins, input logic [31:0] a,
                                          input logic [31:0] b);
        logic lt_s;
        logic lt_u;
        lt_s = ($signed(a) < $signed(b));
        lt_u = (a < b);
        if (ins[6:2] != `OPC_BRANCH_5) return 1'b0;
        case (ins[14:12])
            `FNC_BEQ:  return a == b;
            `FNC_BNE:  return a != b;
            `FNC_BLT:  return lt_s;
            `FNC_BGE:  return !lt_s;
            `FNC_BLTU: return lt_u;
            `FNC_BGEU: return !lt_u;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic logic [1:0] pc_source(input logic r, input logic jal,
        input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
        if (r) return 2'd3;
        if (jal) return 2'd2;
        if (ins[6:2] == `OPC_JALR_5 || branch_taken(ins, a, b)) return 2'd1;
        return 2'd0;
    endfunction

    // {wb_sel, reg_we}
    function automatic logic [2:0] writeback_ctrl(input logic [31:0] ins);
        case (ins[6:2])
            `OPC_LUI_5, `OPC_AUIPC_5, `OPC_ARI_RTYPE_5, `OPC_ARI_ITYPE_5: return 3'b011;
            `OPC_JAL_5, `OPC_JALR_5: return 3'b101;
            `OPC_LOAD_5:             return 3'b001;
            `OPC_BRANCH_5, `OPC_STORE_5: return 3'b000;
            default:                 return 3'b010;
        endcase
    endfunction

    function automatic logic [2:0] region_select(input logic [31:0] a);
        case (a[31:30])
            2'b01:   return 3'd0;
            2'b10:   return 3'd2;
            default: return 3'd1;
        endcase
    endfunction

    function automatic logic [31:0] io_read_value(input logic [31:0] a,
                                                  input ctrl_pkg::uart_in_t u,
                                                  input ctrl_pkg::perf_counts_t m);
        if (a[4]) begin
            if (a == `IO_CYC_ADDR) return m.cyc;
            if (a == `IO_INSTR_ADDR) return m.instr;
            if (a == `IO_BR_ADDR) return m.br;
            if (a == `IO_BR_OK_ADDR) return m.br_ok;
            return 32'd0;
        end
        return a[2] ? {24'd0, u.rx_data} : {30'd0, u.rx_valid, u.tx_ready};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("Error at %0t: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    // counter model sees the same pre-edge inputs as the DUT
    always @(posedge clk) begin
        if (rst || (io_we && addr == `IO_CNT_CLR_ADDR)) begin
            model <= '0;
        end else begin
            model.cyc <= model.cyc + 32'd1;
            if (instruction_s3 != `INSTR_NOP) model.instr <= model.instr + 32'd1;
            if (instruction_s2[6:2] == `OPC_BRANCH_5) begin
                model.br <= model.br + 32'd1;
                if (branch_taken(instruction_s2, rs1, rs2) == br_pred_taken) begin
                    model.br_ok <= model.br_ok + 32'd1;
                end
            end
        end
    end

    // combinational outputs have settled by the falling edge
    always @(negedge clk) begin : compare_outputs
        logic [2:0] exp_wb;
        exp_wb = writeback_ctrl(instruction_s3);
        check("pc_sel", 32'(pc_source(rst, is_jal, instruction_s2, rs1, rs2)), 32'(pc_sel));
        check("wb_sel", 32'(exp_wb[2:1]), 32'(ctrl.wb_sel));
        check("reg_we", 32'(exp_wb[0]), 32'(ctrl.reg_we));
        check("mem_sel", 32'(region_select(addr)), 32'(ctrl.mem_sel));
        check("io_value", io_read_value(addr, uart, model), io_value);
    end

    task automatic report_test(input string name);
        @(posedge clk);
        if (err_count == errs_at_start) begin
            pass_tests++;
            $display("test %s: passed", name);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d errors", name, err_count - errs_at_start);
        end
        errs_at_start = err_count;
    endtask

    task automatic reset_and_jumps();
        @(posedge clk);
        is_jal <= 1'b1;
        instruction_s2 <= make_instr(`OPC_JALR_5, 3'd0);
        @(negedge clk);
        check("pc_sel in reset", 32'd3, 32'(pc_sel));
        repeat (3) @(posedge clk);
        // fifth edge with reset high
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        is_jal <= 1'b0;
        @(posedge clk);
        instruction_s2 <= `INSTR_NOP;
    endtask

    task automatic resolve_branches();
        logic [31:0] r1;
        logic [31:0] r2;
        for (int f = 0; f < 6; f++) begin
            for (int k = 0; k < 6; k++) begin
                r1 = next_rand();
                r2 = next_rand();
                // equal, random, sign-differing both ways, equal negative
                if (k == 0) r2 = r1;
                if (k == 2 || k == 3) begin
                    r1 = r1 | 32'h80000000;
                    r2 = r2 & 32'h7fffffff;
                end
                if (k == 5) begin
                    r1 = 32'h80000000;
                    r2 = 32'h80000000;
                end
                @(posedge clk);
                instruction_s2 <= make_instr(`OPC_BRANCH_5, branch_f3[f]);
                rs1 <= (k == 3) ? r2 : r1;
                rs2 <= (k == 3) ? r1 : r2;
                br_pred_taken <= r1[7];
            end
        end
    endtask

    task automatic decode_writeback();
        logic [31:0] r;
        for (int i = 0; i < 11; i++) begin
            r = next_rand();
            @(posedge clk);
            instruction_s3 <= make_instr(opcodes[i], r[2:0]);
        end
    endtask

    task automatic walk_regions();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            @(posedge clk);
            // top two bits step through all four regions
            addr <= {i[1:0], r[29:0]};
        end
    endtask

    task automatic read_uart();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            @(posedge clk);
            uart.rx_valid <= r[9];
            uart.tx_ready <= r[8];
            uart.rx_data <= r[7:0];
            addr <= {r[31:5], 1'b0, r[3], i[0], r[1:0]};
        end
    endtask

    task automatic run_counters();
        logic [31:0] r;
        logic [31:0] a;
        @(posedge clk);
        io_we <= 1'b1;
        addr <= `IO_CNT_CLR_ADDR;
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            a = next_rand();
            @(posedge clk);
            io_we <= 1'b0;
            instruction_s3 <= r[0] ? `INSTR_NOP : make_instr(`OPC_ARI_RTYPE_5, r[6:4]);
            instruction_s2 <= r[1] ? make_instr(`OPC_BRANCH_5, branch_f3[i % 6]) : `INSTR_NOP;
            rs1 <= a;
            rs2 <= r[2] ? a : next_rand();
            br_pred_taken <= r[3];
            addr <= counter_addrs[i % 4];
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            instruction_s2 <= `INSTR_NOP;
            instruction_s3 <= `INSTR_NOP;
            addr <= counter_addrs[i];
            @(negedge clk);
            check("counter read", io_read_value(counter_addrs[i], uart, model), io_value);
        end
        @(posedge clk);
        io_we <= 1'b1;
        addr <= `IO_CNT_CLR_ADDR;
        @(posedge clk);
        io_we <= 1'b0;
        // only cyc counts after the clear edge while the pipeline stays idle
        for (int i = 0; i < 4; i++) begin
            if (i > 0) @(posedge clk);
            addr <= counter_addrs[i];
            @(negedge clk);
            check("counter after clear", 32'd0, io_value);
        end
    endtask

    initial begin
        rst = 1'b1;
        instruction_s2 = `INSTR_NOP;
        instruction_s3 = `INSTR_NOP;
        rs1 = 32'd0;
        rs2 = 32'd0;
        addr = 32'd0;
        io_we = 1'b0;
        is_jal = 1'b0;
        br_pred_taken = 1'b0;
        uart = '0;
        rng = 32'h6f9f3600;
        reset_and_jumps();
        report_test("reset and jumps");
        resolve_branches();
        report_test("branch resolution");
        decode_writeback();
        report_test("writeback decode");
        walk_regions();
        report_test("memory regions");
        read_uart();
        report_test("uart reads");
        run_counters();
        report_test("performance counters");
        $display("summary: %0d passed, %0d failed", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(test_cycles * 2 * clk_period);
        $display("watchdog expired after %0d cycles, stimulus never finished", test_cycles * 2);
        $display("tests failed");
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/ctrl_pkg.sv
hw/branch_comp.sv
hw/s3_control.sv
hw/perf_counters.sv
hw/cpu_ctrl_top.sv
sim/tb_clock.sv
sim/cpu_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the control testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module cpu_ctrl_tb -f project.f \
    --Mdir obj_dir -o cpu_ctrl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cpu_ctrl_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$log"; then
    exit 1
fi
if ! grep -q "all tests passed" "$log"; then
    echo "no result line found in $log"
    exit 1
fi
exit 0
